//--- tests/tb_lv_core.sv
// lv_core testbench with clock, reset, SPI frame tasks, compare tasks and directed tests
`timescale 1ns/10ps
module tb_lv_core import lv_pkg::*; ();

    localparam int MM_LIMIT = 8;
    localparam int HALF     = 8;     // sclk half period in clocks
    localparam int WAIT_MAX = 200;

    logic i_clk;
    logic i_reset;
    logic i_spi_sclk;
    logic i_spi_csb;
    logic i_spi_mosi;
    logic i_pwr_on;
    logic i_lv_vsup_ov;
    logic i_lv_vsup_uv_n;
    logic i_lv_pwm_dt;
    logic i_lv_pwm_cmp_wave;
    logic i_lv_pwm_gate_wave;
    logic o_spi_miso;
    logic o_pwm_en;
    logic o_intb_n;
    logic [TRIM_NUM-1:0][REG_DW-1:0] o_reg_trim;

    int                seed;
    int                test_errs;
    int                pass_cnt;
    int                fail_cnt;
    string             cur_test;
    logic [REG_DW-1:0] trim_val [TRIM_NUM];

    lv_core #(
        .MM_LIMIT (MM_LIMIT)
    ) dut0 (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_spi_sclk         (i_spi_sclk),
        .i_spi_csb          (i_spi_csb),
        .i_spi_mosi         (i_spi_mosi),
        .o_spi_miso         (o_spi_miso),
        .i_pwr_on           (i_pwr_on),
        .i_lv_vsup_ov       (i_lv_vsup_ov),
        .i_lv_vsup_uv_n     (i_lv_vsup_uv_n),
        .i_lv_pwm_dt        (i_lv_pwm_dt),
        .i_lv_pwm_cmp_wave  (i_lv_pwm_cmp_wave),
        .i_lv_pwm_gate_wave (i_lv_pwm_gate_wave),
        .o_reg_trim         (o_reg_trim),
        .o_pwm_en           (o_pwm_en),
        .o_intb_n           (o_intb_n)
    );

    always #2 i_clk = ~i_clk;

    //============================================================
    // compare tasks
    //============================================================
    task automatic check_byte(input string what, input logic [REG_DW-1:0] exp,
                              input logic [REG_DW-1:0] act);
        if (act !== exp) begin
            $display("Mismatch in %s (%s): expected 0x%02h, actual 0x%02h",
                     cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_state(input ctrl_st_e exp, input ctrl_st_e act);
        if (act !== exp) begin
            $display("Mismatch in %s (state): expected %s, actual %s (%0d)",
                     cur_test, exp.name(), act.name(), act);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch in %s (%s): expected %b, actual %b", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("%s: ok", cur_test);
            pass_cnt++;
        end else begin
            $display("%s: failed with %0d errors", cur_test, test_errs);
            fail_cnt++;
        end
    endtask

    // polls the two pins until both match or the loop runs out
    task automatic wait_pins(input logic exp_pwm, input logic exp_intb);
        int n;
        n = 0;
        while ((o_pwm_en !== exp_pwm || o_intb_n !== exp_intb) && n < WAIT_MAX) begin
            @(negedge i_clk);
            n++;
        end
        if (o_pwm_en !== exp_pwm || o_intb_n !== exp_intb) begin
            $display("%s: timed out waiting for pwm_en %b and intb_n %b",
                     cur_test, exp_pwm, exp_intb);
            test_errs++;
        end
    endtask

    //============================================================
    // SPI master, mode 0
    //============================================================
    task automatic spi_frame(input logic [SPI_FRAME_W-1:0] frame, input int nbits,
                             output logic [REG_DW-1:0] rdata);
        int i;
        rdata = '0;
        @(posedge i_clk);
        i_spi_csb <= 1'b0;
        for (i = 0; i < nbits; i++) begin
            i_spi_mosi <= frame[SPI_FRAME_W-1-i];   // msb first
            repeat (HALF) @(posedge i_clk);
            i_spi_sclk <= 1'b1;
            if (i >= SPI_FRAME_W - REG_DW) begin
                rdata = {rdata[REG_DW-2:0], o_spi_miso};
            end
            repeat (HALF) @(posedge i_clk);
            i_spi_sclk <= 1'b0;
        end
        repeat (HALF) @(posedge i_clk);
        i_spi_csb  <= 1'b1;
        i_spi_mosi <= 1'b0;
        repeat (2 * HALF) @(posedge i_clk);   // gap before next frame
    endtask

    task automatic spi_write(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] data);
        logic [REG_DW-1:0] unused;
        spi_frame({OP_WRITE, addr, data}, SPI_FRAME_W, unused);
    endtask

    task automatic spi_read(input logic [REG_AW-1:0] addr, output logic [REG_DW-1:0] data);
        spi_frame({OP_READ, addr, {REG_DW{1'b0}}}, SPI_FRAME_W, data);
    endtask

    task automatic read_state(input ctrl_st_e exp);
        logic [REG_DW-1:0] b;
        spi_read(ADDR_STATE, b);
        check_state(exp, ctrl_st_e'(b[1:0]));
    endtask

    //============================================================
    // directed tests
    //============================================================
    task automatic test_reset_power();
        start_test("reset_power");
        check_bit("intb_n", 1'b1, o_intb_n);
        check_bit("pwm_en", 1'b0, o_pwm_en);
        check_bit("miso", 1'b0, o_spi_miso);
        @(posedge i_clk);
        i_pwr_on <= 1'b1;
        repeat (2) @(posedge i_clk);
        read_state(ST_CFG);
        end_test();
    endtask

    task automatic test_trim_status();
        int i;
        logic [REG_DW-1:0] b;
        start_test("trim_status");
        for (i = 0; i < TRIM_NUM; i++) begin
            trim_val[i] = $random(seed);
            spi_write(REG_AW'(ADDR_TRIM_BASE + i), trim_val[i]);
        end
        for (i = 0; i < TRIM_NUM; i++) begin
            spi_read(REG_AW'(ADDR_TRIM_BASE + i), b);
            check_byte("trim read", trim_val[i], b);
            check_byte("trim pins", trim_val[i], o_reg_trim[i]);
        end
        spi_read(7'h20, b);
        check_byte("unmapped", 8'h00, b);
        for (i = 0; i < 4; i++) begin   // all ov / uv_n combinations
            @(posedge i_clk);
            i_lv_vsup_ov   <= i[1];
            i_lv_vsup_uv_n <= i[0];
            spi_read(ADDR_STATUS2, b);
            check_byte("status2", {{(REG_DW-2){1'b0}}, i[1], ~i[0]}, b);
        end
        @(posedge i_clk);
        i_lv_vsup_ov   <= 1'b0;
        i_lv_vsup_uv_n <= 1'b1;
        end_test();
    endtask

    task automatic test_normal_lock();
        logic [REG_DW-1:0] b;
        start_test("normal_lock");
        spi_write(ADDR_MODE, 8'h01);
        wait_pins(1'b1, 1'b1);
        read_state(ST_NORMAL);
        spi_write(REG_AW'(ADDR_TRIM_BASE + 2), ~trim_val[2]);
        spi_read(REG_AW'(ADDR_TRIM_BASE + 2), b);
        check_byte("locked trim", trim_val[2], b);
        check_byte("locked trim pins", trim_val[2], o_reg_trim[2]);
        end_test();
    endtask

    task automatic test_mismatch_fault();
        logic [REG_DW-1:0] b;
        start_test("mismatch_fault");
        @(posedge i_clk);
        i_lv_pwm_gate_wave <= 1'b1;   // cmp stays low
        repeat (MM_LIMIT + 4) @(posedge i_clk);
        i_lv_pwm_gate_wave <= 1'b0;
        wait_pins(1'b0, 1'b0);
        spi_read(ADDR_STATUS1, b);
        check_byte("status1", 8'h04, b);
        check_bit("intb_n", 1'b0, o_intb_n);
        read_state(ST_FAULT);
        spi_write(ADDR_STATUS1, 8'h04);
        wait_pins(1'b0, 1'b1);
        read_state(ST_CFG);
        check_bit("intb_n", 1'b1, o_intb_n);
        end_test();
    endtask

    task automatic test_dead_time();
        int i;
        logic [REG_DW-1:0] b;
        start_test("dead_time");
        spi_write(ADDR_DEAD_TIME, 8'd5);
        trim_val[TRIM_NUM-1] = 8'd5;
        check_byte("dead time pins", trim_val[TRIM_NUM-1], o_reg_trim[TRIM_NUM-1]);
        spi_write(ADDR_MODE, 8'h01);
        wait_pins(1'b1, 1'b1);
        for (i = 0; i < 4; i++) begin   // short pulses below the limit
            @(posedge i_clk);
            i_lv_pwm_dt <= 1'b1;
            repeat (3) @(posedge i_clk);
            i_lv_pwm_dt <= 1'b0;
            repeat (6) @(posedge i_clk);
        end
        spi_read(ADDR_STATUS1, b);
        check_byte("status1 after short pulses", 8'h00, b);
        @(posedge i_clk);
        i_lv_pwm_dt <= 1'b1;
        repeat (20) @(posedge i_clk);
        i_lv_pwm_dt <= 1'b0;
        wait_pins(1'b0, 1'b0);
        spi_read(ADDR_STATUS1, b);
        check_byte("status1", 8'h02, b);
        spi_write(ADDR_STATUS1, 8'h02);
        wait_pins(1'b0, 1'b1);
        end_test();
    endtask

    task automatic test_short_frame();
        logic [REG_DW-1:0] b;
        start_test("short_frame");
        spi_frame({OP_WRITE, REG_AW'(ADDR_TRIM_BASE + 3), ~trim_val[3]}, 10, b);
        spi_read(ADDR_STATUS1, b);
        check_byte("status1", 8'h01, b);
        read_state(ST_FAULT);
        spi_read(REG_AW'(ADDR_TRIM_BASE + 3), b);
        check_byte("trim after short frame", trim_val[3], b);
        check_byte("trim pins", trim_val[3], o_reg_trim[3]);
        spi_write(ADDR_STATUS1, 8'h01);
        wait_pins(1'b0, 1'b1);
        end_test();
    endtask

    //============================================================
    // main sequence
    //============================================================
    initial begin
        i_clk              = 1'b0;
        i_reset            = 1'b1;
        i_spi_sclk         = 1'b0;
        i_spi_csb          = 1'b1;
        i_spi_mosi         = 1'b0;
        i_pwr_on           = 1'b0;
        i_lv_vsup_ov       = 1'b0;
        i_lv_vsup_uv_n     = 1'b1;
        i_lv_pwm_dt        = 1'b0;
        i_lv_pwm_cmp_wave  = 1'b0;
        i_lv_pwm_gate_wave = 1'b0;
        seed               = 16629;
        pass_cnt           = 0;
        fail_cnt           = 0;
        repeat (4) @(posedge i_clk);
        i_reset <= 1'b0;
        @(posedge i_clk);
        test_reset_power();
        test_trim_status();
        test_normal_lock();
        test_mismatch_fault();
        test_dead_time();
        test_short_frame();
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verilog/lv_core.sv
// LV die digital core with SPI slave, register slave, control FSM and PWM monitor
`timescale 1ns/10ps
module lv_core import lv_pkg::*; #(
    parameter int MM_LIMIT = 8
) (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_spi_sclk,
    input  logic                            i_spi_csb,
    input  logic                            i_spi_mosi,
    output logic                            o_spi_miso,
    input  logic                            i_pwr_on,
    input  logic                            i_lv_vsup_ov,
    input  logic                            i_lv_vsup_uv_n,
    input  logic                            i_lv_pwm_dt,
    input  logic                            i_lv_pwm_cmp_wave,
    input  logic                            i_lv_pwm_gate_wave,
    output logic [TRIM_NUM-1:0][REG_DW-1:0] o_reg_trim,
    output logic                            o_pwm_en,
    output logic                            o_intb_n
);

    //============================================================
    // internal nets
    //============================================================
    logic              spi_req_valid;
    spi_op_e           spi_req_op;
    logic [REG_AW-1:0] spi_req_addr;
    logic [REG_DW-1:0] spi_req_wdata;
    logic              reg_rsp_valid;
    logic [REG_DW-1:0] reg_rsp_rdata;
    logic              spi_err;
    logic              spi_en;
    logic              cmd_normal;
    logic              err_any;
    ctrl_st_e          cur_st;
    logic              cfg_wr_en;
    logic [REG_DW-1:0] dead_time;
    logic              pwm_dterr;
    logic              pwm_mmerr;

    lv_spi_slv u_spi_slv (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_spi_sclk  (i_spi_sclk),
        .i_spi_csb   (i_spi_csb),
        .i_spi_mosi  (i_spi_mosi),
        .i_spi_en    (spi_en),
        .o_spi_miso  (o_spi_miso),
        .o_req_valid (spi_req_valid),
        .o_req_op    (spi_req_op),
        .o_req_addr  (spi_req_addr),
        .o_req_wdata (spi_req_wdata),
        .i_rsp_valid (reg_rsp_valid),
        .i_rsp_rdata (reg_rsp_rdata),
        .o_spi_err   (spi_err)
    );

    lv_reg_slv u_reg_slv (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_req_valid    (spi_req_valid),
        .i_req_op       (spi_req_op),
        .i_req_addr     (spi_req_addr),
        .i_req_wdata    (spi_req_wdata),
        .o_rsp_valid    (reg_rsp_valid),
        .o_rsp_rdata    (reg_rsp_rdata),
        .i_spi_err      (spi_err),
        .i_pwm_dterr    (pwm_dterr),
        .i_pwm_mmerr    (pwm_mmerr),
        .i_lv_vsup_ov   (i_lv_vsup_ov),
        .i_lv_vsup_uv_n (i_lv_vsup_uv_n),
        .i_cur_st       (cur_st),
        .i_cfg_wr_en    (cfg_wr_en),
        .o_cmd_normal   (cmd_normal),
        .o_err_any      (err_any),
        .o_reg_trim     (o_reg_trim),
        .o_dead_time    (dead_time)
    );

    lv_ctrl_unit u_ctrl_unit (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_pwr_on     (i_pwr_on),
        .i_cmd_normal (cmd_normal),
        .i_err_any    (err_any),
        .o_cur_st     (cur_st),
        .o_spi_en     (spi_en),
        .o_cfg_wr_en  (cfg_wr_en),
        .o_pwm_en     (o_pwm_en),
        .o_intb_n     (o_intb_n)
    );

    lv_pwm_mon #(
        .MM_LIMIT (MM_LIMIT)
    ) u_pwm_mon (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_pwm_en           (o_pwm_en),
        .i_lv_pwm_dt        (i_lv_pwm_dt),
        .i_lv_pwm_cmp_wave  (i_lv_pwm_cmp_wave),
        .i_lv_pwm_gate_wave (i_lv_pwm_gate_wave),
        .i_dead_time        (dead_time),
        .o_pwm_mmerr        (pwm_mmerr),
        .o_pwm_dterr        (pwm_dterr)
    );

endmodule

//--- verilog/lv_ctrl_unit.sv
// operating state machine with interrupt, SPI, config and PWM enables
`timescale 1ns/10ps
module lv_ctrl_unit import lv_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_pwr_on,
    input  logic     i_cmd_normal,
    input  logic     i_err_any,
    output ctrl_st_e o_cur_st,
    output logic     o_spi_en,
    output logic     o_cfg_wr_en,
    output logic     o_pwm_en,
    output logic     o_intb_n
);

    ctrl_st_e nxt_st;

    //============================================================
    // next state
    //============================================================
    always_comb begin
        nxt_st = o_cur_st;
        case (o_cur_st)
            ST_INIT: begin
                if (i_pwr_on) begin
                    nxt_st = ST_CFG;
                end
            end
            ST_CFG: begin
                if (i_err_any) begin
                    nxt_st = ST_FAULT;   // e.g. bad SPI frame
                end else if (i_cmd_normal) begin
                    nxt_st = ST_NORMAL;
                end
            end
            ST_NORMAL: begin
                if (i_err_any) begin
                    nxt_st = ST_FAULT;
                end
            end
            ST_FAULT: begin
                if (!i_err_any) begin
                    nxt_st = ST_CFG;     // flags cleared by host
                end
            end
            default: nxt_st = ST_INIT;
        endcase
    end

    //============================================================
    // state and registered outputs
    //============================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_cur_st    <= ST_INIT;
            o_spi_en    <= 1'b0;
            o_cfg_wr_en <= 1'b0;
            o_pwm_en    <= 1'b0;
            o_intb_n    <= 1'b1;
        end else begin
            o_cur_st    <= nxt_st;
            o_spi_en    <= nxt_st != ST_INIT;
            o_cfg_wr_en <= nxt_st == ST_CFG;
            o_pwm_en    <= nxt_st == ST_NORMAL;
            o_intb_n    <= nxt_st != ST_FAULT;   // low active
        end
    end

endmodule

//--- verilog/lv_pkg.sv
// shared widths, register addresses, status1 bits, opcode and state enums
package lv_pkg;

    //============================================================
    // widths
    //============================================================
    localparam int REG_AW      = 7;
    localparam int REG_DW      = 8;
    localparam int SPI_FRAME_W = 16;   // r/w bit + addr + data
    localparam int TRIM_NUM    = 10;

    //============================================================
    // register map
    //============================================================
    localparam logic [REG_AW-1:0] ADDR_MODE      = 7'h00;
    localparam logic [REG_AW-1:0] ADDR_STATUS1   = 7'h01;   // sticky error flags
    localparam logic [REG_AW-1:0] ADDR_STATUS2   = 7'h02;   // supply levels
    localparam logic [REG_AW-1:0] ADDR_STATE     = 7'h03;
    localparam logic [REG_AW-1:0] ADDR_TRIM_BASE = 7'h10;
    localparam logic [REG_AW-1:0] ADDR_DEAD_TIME = 7'h19;   // last trim byte

    // status1 flag positions
    localparam int ERR_SPI    = 0;
    localparam int ERR_PWM_DT = 1;
    localparam int ERR_PWM_MM = 2;

    // bit 15 of the frame
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } spi_op_e;

    typedef enum logic [1:0] {
        ST_INIT   = 2'd0,
        ST_CFG    = 2'd1,
        ST_NORMAL = 2'd2,
        ST_FAULT  = 2'd3
    } ctrl_st_e;

endpackage

//--- verilog/lv_pwm_mon.sv
// PWM gate/compare mismatch and dead-time length checkers
`timescale 1ns/10ps
module lv_pwm_mon import lv_pkg::*; #(
    parameter int MM_LIMIT = 8
) (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_pwm_en,
    input  logic              i_lv_pwm_dt,
    input  logic              i_lv_pwm_cmp_wave,
    input  logic              i_lv_pwm_gate_wave,
    input  logic [REG_DW-1:0] i_dead_time,
    output logic              o_pwm_mmerr,
    output logic              o_pwm_dterr
);

    localparam int MM_W = $clog2(MM_LIMIT + 1);

    logic            mismatch;
    logic            dt_on;
    logic [MM_W-1:0] mm_cnt;
    logic [REG_DW:0] dt_cnt;   // one extra bit to pass the limit

    assign mismatch = i_pwm_en && (i_lv_pwm_gate_wave ^ i_lv_pwm_cmp_wave);
    assign dt_on    = i_pwm_en && i_lv_pwm_dt;

    // both counters stop one past their limit, so one pulse per episode
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            mm_cnt      <= '0;
            dt_cnt      <= '0;
            o_pwm_mmerr <= 1'b0;
            o_pwm_dterr <= 1'b0;
        end else begin
            o_pwm_mmerr <= mismatch && mm_cnt == MM_W'(MM_LIMIT - 1);
            o_pwm_dterr <= dt_on && dt_cnt == {1'b0, i_dead_time};
            if (!mismatch) begin
                mm_cnt <= '0;
            end else if (mm_cnt != MM_W'(MM_LIMIT)) begin
                mm_cnt <= mm_cnt + 1'b1;
            end
            if (!dt_on) begin
                dt_cnt <= '0;
            end else if (dt_cnt <= {1'b0, i_dead_time}) begin
                dt_cnt <= dt_cnt + 1'b1;
            end
        end
    end

endmodule

//--- verilog/lv_reg_slv.sv
// register map with trim lock, sticky status1 flags and status read mux
`timescale 1ns/10ps
module lv_reg_slv import lv_pkg::*; (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_req_valid,
    input  spi_op_e                         i_req_op,
    input  logic [REG_AW-1:0]               i_req_addr,
    input  logic [REG_DW-1:0]               i_req_wdata,
    output logic                            o_rsp_valid,
    output logic [REG_DW-1:0]               o_rsp_rdata,
    input  logic                            i_spi_err,
    input  logic                            i_pwm_dterr,
    input  logic                            i_pwm_mmerr,
    input  logic                            i_lv_vsup_ov,
    input  logic                            i_lv_vsup_uv_n,
    input  ctrl_st_e                        i_cur_st,
    input  logic                            i_cfg_wr_en,
    output logic                            o_cmd_normal,
    output logic                            o_err_any,
    output logic [TRIM_NUM-1:0][REG_DW-1:0] o_reg_trim,
    output logic [REG_DW-1:0]               o_dead_time
);

    localparam int DT_IDX = ADDR_DEAD_TIME - ADDR_TRIM_BASE;

    logic              wr_req;
    logic              rd_req;
    logic              in_trim;
    logic [REG_AW-1:0] trim_idx;
    logic [REG_DW-1:0] st1_q;
    logic [REG_DW-1:0] err_set;
    logic [REG_DW-1:0] rd_mux;

    assign wr_req   = i_req_valid && i_req_op == OP_WRITE;
    assign rd_req   = i_req_valid && i_req_op == OP_READ;
    assign trim_idx = i_req_addr - ADDR_TRIM_BASE;
    assign in_trim  = i_req_addr >= ADDR_TRIM_BASE && trim_idx < REG_AW'(TRIM_NUM);

    always_comb begin
        err_set             = '0;
        err_set[ERR_SPI]    = i_spi_err;
        err_set[ERR_PWM_DT] = i_pwm_dterr;
        err_set[ERR_PWM_MM] = i_pwm_mmerr;
    end

    //============================================================
    // read mux
    //============================================================
    always_comb begin
        rd_mux = '0;
        if (in_trim) begin
            rd_mux = o_reg_trim[trim_idx];
        end else begin
            case (i_req_addr)
                ADDR_STATUS1: rd_mux = st1_q;
                ADDR_STATUS2: rd_mux = {{(REG_DW-2){1'b0}}, i_lv_vsup_ov, ~i_lv_vsup_uv_n};
                ADDR_STATE:   rd_mux = {{(REG_DW-$bits(ctrl_st_e)){1'b0}}, i_cur_st};
                default:      rd_mux = '0;   // mode reg and holes
            endcase
        end
    end

    //============================================================
    // writes, flags and response
    //============================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_reg_trim   <= '0;
            st1_q        <= '0;
            o_cmd_normal <= 1'b0;
            o_rsp_valid  <= 1'b0;
            o_rsp_rdata  <= '0;
        end else begin
            o_rsp_valid  <= rd_req;
            o_cmd_normal <= wr_req && i_req_addr == ADDR_MODE && i_req_wdata[0];
            if (rd_req) begin
                o_rsp_rdata <= rd_mux;
            end
            if (wr_req && i_cfg_wr_en && in_trim) begin
                o_reg_trim[trim_idx] <= i_req_wdata;   // locked outside cfg
            end
            // a new error wins over a clear in the same cycle
            if (wr_req && i_req_addr == ADDR_STATUS1) begin
                st1_q <= (st1_q & ~i_req_wdata) | err_set;
            end else begin
                st1_q <= st1_q | err_set;
            end
        end
    end

    assign o_err_any   = |st1_q;
    assign o_dead_time = o_reg_trim[DT_IDX];

endmodule

//--- verilog/lv_spi_slv.sv
// SPI mode 0 slave with pin sync, frame decode, register request and MISO read-back
`timescale 1ns/10ps
module lv_spi_slv import lv_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_spi_sclk,
    input  logic                 i_spi_csb,
    input  logic                 i_spi_mosi,
    input  logic                 i_spi_en,
    output logic                 o_spi_miso,
    output logic                 o_req_valid,
    output spi_op_e              o_req_op,
    output logic [REG_AW-1:0]    o_req_addr,
    output logic [REG_DW-1:0]    o_req_wdata,
    input  logic                 i_rsp_valid,
    input  logic [REG_DW-1:0]    i_rsp_rdata,
    output logic                 o_spi_err
);

    localparam int CNT_W    = $clog2(SPI_FRAME_W) + 1;
    localparam int HDR_BITS = SPI_FRAME_W - REG_DW;   // op + addr

    logic [2:0]          sclk_q;
    logic [2:0]          csb_q;
    logic [1:0]          mosi_q;
    logic                sclk_rise;
    logic                sclk_fall;
    logic                csb_rise;
    logic                frame_act;
    logic [CNT_W-1:0]    bit_cnt;
    logic [REG_DW-1:0]   shift_q;
    logic [HDR_BITS-1:0] hdr_q;
    logic [REG_DW-1:0]   tx_q;

    //============================================================
    // pin synchronizers and edge detect
    //============================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sclk_q <= '0;
            csb_q  <= '1;   // idle high
            mosi_q <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], i_spi_sclk};
            csb_q  <= {csb_q[1:0], i_spi_csb};
            mosi_q <= {mosi_q[0], i_spi_mosi};
        end
    end

    assign sclk_rise = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall = ~sclk_q[1] & sclk_q[2];
    assign csb_rise  = csb_q[1] & ~csb_q[2];
    assign frame_act = ~csb_q[1] & i_spi_en;

    //============================================================
    // bit counter, shifter and requests
    //============================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            bit_cnt     <= '0;
            shift_q     <= '0;
            hdr_q       <= '0;
            o_req_valid <= 1'b0;
            o_spi_err   <= 1'b0;
        end else begin
            o_req_valid <= 1'b0;
            o_spi_err   <= 1'b0;
            if (!frame_act) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                shift_q <= {shift_q[REG_DW-2:0], mosi_q[1]};
                if (bit_cnt != '1) begin
                    bit_cnt <= bit_cnt + 1'b1;   // saturate on long frames
                end
                if (bit_cnt == CNT_W'(HDR_BITS - 1)) begin
                    hdr_q       <= {shift_q[HDR_BITS-2:0], mosi_q[1]};
                    o_req_valid <= spi_op_e'(shift_q[HDR_BITS-2]) == OP_READ;
                end
                if (bit_cnt == CNT_W'(SPI_FRAME_W - 1) &&
                    spi_op_e'(hdr_q[HDR_BITS-1]) == OP_WRITE) begin
                    o_req_valid <= 1'b1;
                end
            end
            // short or long frame
            if (csb_rise && i_spi_en && bit_cnt != CNT_W'(SPI_FRAME_W)) begin
                o_spi_err <= 1'b1;
            end
        end
    end

    assign o_req_op    = spi_op_e'(hdr_q[HDR_BITS-1]);
    assign o_req_addr  = hdr_q[REG_AW-1:0];
    assign o_req_wdata = shift_q;

    // read data shifts out MSB first on falling edges
    always_ff @(posedge i_clk) begin
        if (i_reset || !frame_act) begin
            tx_q       <= '0;
            o_spi_miso <= 1'b0;
        end else if (i_rsp_valid) begin
            tx_q <= i_rsp_rdata;
        end else if (sclk_fall) begin
            o_spi_miso <= tx_q[REG_DW-1];
            tx_q       <= {tx_q[REG_DW-2:0], 1'b0};
        end
    end

endmodule

//--- vlog.f
verilog/lv_pkg.sv
verilog/lv_spi_slv.sv
verilog/lv_reg_slv.sv
verilog/lv_ctrl_unit.sv
verilog/lv_pwm_mon.sv
verilog/lv_core.sv
tests/tb_lv_core.sv
